// File: pmp_unit_top.f
+incdir+sim
src/pmp_pkg.sv
src/mem_cfg_pkg.sv
src/pmp_check.sv
src/pmp_csr_regs.sv
src/pmp_access_guard.sv
src/pmp_unit_top.sv
sim/pmp_unit_tb.sv

// File: sim/pmp_ref_model.svh
`ifndef PMP_REF_MODEL_SVH
`define PMP_REF_MODEL_SVH

// ----------------------------------------------------------------------
// reference copy of the entry registers
// ----------------------------------------------------------------------

logic [7:0]  m_cfg [NR_PMP_ENTRIES];
logic [29:0] m_addr [NR_PMP_ENTRIES];

// lfsr state, seeded by the testbench
logic [31:0] lfsr_state;

// fibonacci lfsr, taps 32 22 2 1
// one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r = {r[30:0], fb};
  end
  return r;
endfunction

function automatic void model_reset();
  for (int i = 0; i < NR_PMP_ENTRIES; i++) begin
    m_cfg[i]  = 8'h00;
    m_addr[i] = 30'h0;
  end
endfunction

// locked entry keeps its value, w without r drops w
function automatic void model_cfg_write(input int idx, input logic [31:0] wdata);
  logic [7:0] v;
  v = wdata[7:0];
  if (v[CFG_W_BIT] && !v[CFG_R_BIT]) begin
    v[CFG_W_BIT] = 1'b0;
  end
  if (!m_cfg[idx][CFG_L_BIT]) begin
    m_cfg[idx] = v;
  end
endfunction

// also frozen while the next entry is a locked tor
function automatic void model_addr_write(input int idx, input logic [31:0] wdata);
  logic frozen;
  frozen = m_cfg[idx][CFG_L_BIT];
  if (idx < NR_PMP_ENTRIES - 1) begin
    frozen = frozen || (m_cfg[idx+1][CFG_L_BIT] &&
                        m_cfg[idx+1][CFG_A_LSB +: 2] == 2'b01);
  end
  if (!frozen) begin
    m_addr[idx] = wdata[29:0];
  end
endfunction

// region test per mode, napot size is 2^(trailing ones + 3) bytes
function automatic logic model_match(input int idx, input logic [31:0] addr);
  logic [63:0] lo;
  logic [63:0] hi;
  int          ones;
  lo = (idx == 0) ? 64'd0 : {32'd0, m_addr[idx-1], 2'b00};
  hi = {32'd0, m_addr[idx], 2'b00};
  ones = 0;
  while (ones < 30 && m_addr[idx][ones]) begin
    ones++;
  end
  case (pmp_mode_e'(m_cfg[idx][CFG_A_LSB +: 2]))
    TOR:     return ({32'd0, addr} >= lo) && ({32'd0, addr} < hi);
    NA4:     return addr[31:2] == m_addr[idx];
    NAPOT:   return ({32'd0, addr} >> (ones + 3)) == (hi >> (ones + 3));
    default: return 1'b0;
  endcase
endfunction

// first matching entry wins
function automatic logic model_allow(input logic [31:0] addr, input priv_lvl_e priv,
                                     input int perm_bit);
  for (int i = 0; i < NR_PMP_ENTRIES; i++) begin
    if (model_match(i, addr)) begin
      if (priv == PRIV_M) begin
        return !m_cfg[i][CFG_L_BIT] || m_cfg[i][perm_bit];
      end
      return m_cfg[i][perm_bit];
    end
  end
  // nothing matched
  return priv == PRIV_M;
endfunction

`endif

// File: sim/pmp_unit_tb.sv
`timescale 1ns/10ps

module pmp_unit_tb
  import pmp_pkg::*;
  import mem_cfg_pkg::*;
();

  logic clk_i, rst_ni, csr_cfg_we_i, csr_addr_we_i;
  logic [PMP_IDX_W-1:0] csr_idx_i;
  logic [31:0] csr_wdata_i;
  logic [7:0] csr_cfg_rdata_o;
  logic [29:0] csr_addr_rdata_o;
  priv_lvl_e priv_lvl_i, ld_st_priv_lvl_i;
  logic fetch_valid_i, fetch_ex_valid_i, fetch_valid_o, fetch_ex_valid_o;
  logic [31:0] fetch_paddr_i, fetch_vaddr_i, fetch_ex_cause_i, fetch_ex_tval_i;
  logic [31:0] fetch_paddr_o, fetch_ex_cause_o, fetch_ex_tval_o;
  logic lsu_valid_i, lsu_is_store_i, lsu_ex_valid_i, lsu_valid_o, lsu_ex_valid_o;
  logic [31:0] lsu_paddr_i, lsu_vaddr_i, lsu_ex_cause_i, lsu_ex_tval_i;
  logic [31:0] lsu_paddr_o, lsu_ex_cause_o, lsu_ex_tval_o;

  // bookkeeping
  string cur_test;
  int    checks, errors, test_checks, test_errs;
  bit    hung;

  `include "pmp_ref_model.svh"

  pmp_unit_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // drive point 2 ns after the edge, sample 2 ns before the next
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic settle();
    #16;
  endtask

  task automatic compare_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
    test_checks++;
    assert (act === exp) else begin
      $display("error %s %s: expected %h, actual %h", cur_test, field, exp, act);
      test_errs++;
    end
  endtask

  task automatic reset_dut();
    int n;
    rst_ni = 1'b0;
    csr_cfg_we_i = 1'b0;
    csr_addr_we_i = 1'b0;
    csr_idx_i = '0;
    model_reset();
    repeat (8) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    // readback of entry 0 must be clear
    n = 0;
    while (n < 10 && (csr_cfg_rdata_o !== 8'h00 || csr_addr_rdata_o !== 30'h0)) begin
      next_cycle();
      n++;
    end
    if (n == 10) begin
      $display("timeout: register readback still not zero 10 cycles after reset");
      hung = 1'b1;
    end
  endtask

  // one strobe cycle, the model follows after the edge
  task automatic write_entry(input logic is_cfg, input int idx, input logic [31:0] wdata);
    csr_idx_i = PMP_IDX_W'(idx);
    csr_wdata_i = wdata;
    csr_cfg_we_i = is_cfg;
    csr_addr_we_i = !is_cfg;
    next_cycle();
    csr_cfg_we_i = 1'b0;
    csr_addr_we_i = 1'b0;
    if (is_cfg) model_cfg_write(idx, wdata);
    else model_addr_write(idx, wdata);
  endtask

  task automatic check_readback(input int idx);
    csr_idx_i = PMP_IDX_W'(idx);
    settle();
    compare_value("cfg readback", m_cfg[idx], csr_cfg_rdata_o);
    compare_value("addr readback", m_addr[idx], csr_addr_rdata_o);
    next_cycle();
  endtask

  // 2'b10 is reserved, fold it into m mode
  function automatic priv_lvl_e rand_priv();
    logic [1:0] v;
    v = rand_bits(2);
    if (v == 2'b10) return PRIV_M;
    return priv_lvl_e'(v);
  endfunction

  // lock bit set only now and then
  function automatic logic [31:0] rand_cfg();
    logic [31:0] r;
    r = rand_bits(32);
    r[CFG_L_BIT] = (rand_bits(3) == 0);
    return r;
  endfunction

  // entry addresses near the exec base, sometimes with napot trailing ones
  function automatic logic [31:0] rand_entry_addr();
    logic [29:0] w;
    w = EXEC_BASE[31:2] + rand_bits(10);
    if (rand_bits(1)) w = w | ((30'd1 << rand_bits(3)) - 30'd1);
    return {2'b00, w};
  endfunction

  // access addresses biased onto entry and region edges
  function automatic logic [31:0] pick_addr();
    logic [1:0]  sel;
    logic [31:0] off;
    sel = rand_bits(2);
    off = rand_bits(4) - 32'd8;
    case (sel)
      2'd0: return {m_addr[rand_bits(3)], 2'b00} + off;
      2'd1: return EXEC_BASE + off;
      2'd2: return EXEC_BASE + EXEC_SIZE + off;
      default: return rand_bits(32);
    endcase
  endfunction

  // random side fields, then both paths compared with the model
  task automatic drive_access(input priv_lvl_e fp, input priv_lvl_e dp,
                              input logic [31:0] faddr, input logic [31:0] daddr);
    logic f_deny, d_deny;
    priv_lvl_i = fp;
    ld_st_priv_lvl_i = dp;
    fetch_valid_i = rand_bits(1);
    fetch_paddr_i = faddr;
    fetch_vaddr_i = rand_bits(32);
    fetch_ex_valid_i = rand_bits(1);
    fetch_ex_cause_i = rand_bits(5);
    fetch_ex_tval_i = rand_bits(32);
    lsu_valid_i = rand_bits(1);
    lsu_paddr_i = daddr;
    lsu_vaddr_i = rand_bits(32);
    lsu_is_store_i = rand_bits(1);
    lsu_ex_valid_i = rand_bits(1);
    lsu_ex_cause_i = rand_bits(5);
    lsu_ex_tval_i = rand_bits(32);
    settle();
    // fetch faults outside the region whether valid or not
    f_deny = (faddr < EXEC_BASE) || ({1'b0, faddr} >= {1'b0, EXEC_BASE} + EXEC_SIZE) ||
             !model_allow(faddr, fp, CFG_X_BIT);
    d_deny = lsu_valid_i && !model_allow(daddr, dp, lsu_is_store_i ? CFG_W_BIT : CFG_R_BIT);
    compare_value("fetch_valid_o", fetch_valid_i, fetch_valid_o);
    compare_value("fetch_paddr_o", faddr, fetch_paddr_o);
    compare_value("fetch_ex_valid_o", f_deny | fetch_ex_valid_i, fetch_ex_valid_o);
    compare_value("fetch_ex_cause_o", f_deny ? CAUSE_INSTR_ACCESS_FAULT : fetch_ex_cause_i,
                  fetch_ex_cause_o);
    compare_value("fetch_ex_tval_o", f_deny ? fetch_vaddr_i : fetch_ex_tval_i, fetch_ex_tval_o);
    compare_value("lsu_valid_o", lsu_valid_i, lsu_valid_o);
    compare_value("lsu_paddr_o", daddr, lsu_paddr_o);
    compare_value("lsu_ex_valid_o", d_deny | lsu_ex_valid_i, lsu_ex_valid_o);
    compare_value("lsu_ex_cause_o", !d_deny ? lsu_ex_cause_i :
                  lsu_is_store_i ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT, lsu_ex_cause_o);
    compare_value("lsu_ex_tval_o", d_deny ? lsu_vaddr_i : lsu_ex_tval_i, lsu_ex_tval_o);
    next_cycle();
  endtask

  task automatic random_traffic(input int n_entries, input int n_access);
    int idx;
    repeat (n_entries) begin
      idx = rand_bits(3);
      write_entry(1'b0, idx, rand_entry_addr());
      write_entry(1'b1, idx, rand_cfg());
    end
    repeat (n_access) drive_access(rand_priv(), rand_priv(), pick_addr(), pick_addr());
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    checks += test_checks;
    errors += test_errs;
    test_checks = 0;
    test_errs = 0;
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    int idx;
    priv_lvl_e pl;
    lfsr_state = 32'hd836_5451;
    {rst_ni, csr_cfg_we_i, csr_addr_we_i, csr_idx_i, csr_wdata_i} = '0;
    priv_lvl_i = PRIV_M;
    ld_st_priv_lvl_i = PRIV_M;
    {fetch_valid_i, fetch_paddr_i, fetch_vaddr_i, fetch_ex_valid_i} = '0;
    {fetch_ex_cause_i, fetch_ex_tval_i} = '0;
    {lsu_valid_i, lsu_paddr_i, lsu_vaddr_i, lsu_is_store_i} = '0;
    {lsu_ex_valid_i, lsu_ex_cause_i, lsu_ex_tval_i} = '0;
    {checks, errors, test_checks, test_errs, hung} = '0;

    cur_test = "reset_state";
    reset_dut();
    for (int i = 0; i < NR_PMP_ENTRIES; i++) check_readback(i);
    drive_access(PRIV_M, PRIV_M, EXEC_BASE + rand_bits(28), pick_addr());
    finish_test();

    // w without r on entry 2
    // entry 4 locked tor freezes itself and the addr of entry 3
    cur_test = "register_rules";
    reset_dut();
    write_entry(1'b1, 2, 32'h0000_0002);
    check_readback(2);
    write_entry(1'b1, 4, 32'h0000_0088);
    write_entry(1'b0, 3, rand_entry_addr());
    check_readback(3);
    write_entry(1'b0, 4, rand_entry_addr());
    write_entry(1'b1, 4, 32'h0000_001f);
    check_readback(4);
    // further locks and w without r come from rand_cfg
    repeat (60) begin
      idx = rand_bits(3);
      if (rand_bits(1)) write_entry(1'b1, idx, rand_cfg());
      else write_entry(1'b0, idx, rand_entry_addr());
      check_readback(idx);
    end
    finish_test();

    cur_test = "fetch_checks";
    reset_dut();
    random_traffic(8, 80);
    finish_test();

    cur_test = "lsu_checks";
    reset_dut();
    random_traffic(8, 80);
    finish_test();

    // entry 0 na4 on the base word without permissions
    // entry 1 napot 64 bytes at the base with rwx
    cur_test = "priority_locking";
    reset_dut();
    write_entry(1'b0, 0, {2'b00, EXEC_BASE[31:2]});
    write_entry(1'b1, 0, 32'h10);
    write_entry(1'b0, 1, {2'b00, EXEC_BASE[31:2]} | 32'h7);
    write_entry(1'b1, 1, 32'h1f);
    repeat (2) begin
      for (int p = 0; p < 4; p++) begin
        pl = (p == 2) ? PRIV_M : priv_lvl_e'(p);
        drive_access(pl, pl, EXEC_BASE, EXEC_BASE);
        drive_access(pl, pl, EXEC_BASE + 32'd4, EXEC_BASE + 32'd4);
        drive_access(pl, pl, EXEC_BASE + 32'd64, EXEC_BASE + 32'd64);
      end
      // second round with entry 0 locked
      write_entry(1'b1, 0, 32'h90);
    end
    finish_test();

    // entry 0 napot over the whole space with rwx
    cur_test = "pass_through";
    reset_dut();
    write_entry(1'b0, 0, 32'h3fff_ffff);
    write_entry(1'b1, 0, 32'h1f);
    repeat (40) drive_access(rand_priv(), rand_priv(), EXEC_BASE + rand_bits(28), pick_addr());
    finish_test();

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !hung) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #1_000_000;
    $display("timeout: simulation ran past its time limit");
    $display("Checks failed");
    $finish;
  end

endmodule

// File: src/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // ------------------------------------------------------------------
  // datapath widths
  // ------------------------------------------------------------------

  // register width, also width of cause and tval
  localparam int XLEN = 32;
  // virtual address width, used for tval only
  localparam int VLEN = 32;
  // physical address width
  localparam int PLEN = 32;

  // ------------------------------------------------------------------
  // pmp entry geometry
  // ------------------------------------------------------------------

  // pmpaddr holds address bits [PLEN-1:2]
  localparam int PMP_ADDR_W = PLEN - 2;

  // number of implemented entries
  localparam int NR_PMP_ENTRIES = 8;

  // entry index width
  localparam int PMP_IDX_W = 3;

  // ------------------------------------------------------------------
  // executable region (pma)
  // ------------------------------------------------------------------

  // single region, fetches outside it fault regardless of pmp
  localparam logic [PLEN-1:0] EXEC_BASE = 32'h8000_0000;
  localparam logic [PLEN-1:0] EXEC_SIZE = 32'h1000_0000;

  // ------------------------------------------------------------------
  // exception cause codes
  // ------------------------------------------------------------------

  // instruction access fault
  localparam logic [XLEN-1:0] CAUSE_INSTR_ACCESS_FAULT = 32'd1;
  // load access fault
  localparam logic [XLEN-1:0] CAUSE_LD_ACCESS_FAULT    = 32'd5;
  // store/amo access fault
  localparam logic [XLEN-1:0] CAUSE_ST_ACCESS_FAULT    = 32'd7;

endpackage

// File: src/pmp_access_guard.sv
`timescale 1ns/10ps

module pmp_access_guard
  import pmp_pkg::*;
  import mem_cfg_pkg::*;
(
  // fetch request
  input  logic                  fetch_valid_i,
  input  logic [PLEN-1:0]       fetch_paddr_i,
  // virtual address, reported as tval only
  input  logic [VLEN-1:0]       fetch_vaddr_i,
  // upstream fetch fault
  input  logic                  fetch_ex_valid_i,
  input  logic [XLEN-1:0]       fetch_ex_cause_i,
  input  logic [XLEN-1:0]       fetch_ex_tval_i,
  // fetch towards memory
  output logic                  fetch_valid_o,
  output logic [PLEN-1:0]       fetch_paddr_o,
  output logic                  fetch_ex_valid_o,
  output logic [XLEN-1:0]       fetch_ex_cause_o,
  output logic [XLEN-1:0]       fetch_ex_tval_o,
  // load/store request
  input  logic                  lsu_valid_i,
  input  logic [PLEN-1:0]       lsu_paddr_i,
  input  logic [VLEN-1:0]       lsu_vaddr_i,
  input  logic                  lsu_is_store_i,
  // upstream load/store fault, e.g. misaligned
  input  logic                  lsu_ex_valid_i,
  input  logic [XLEN-1:0]       lsu_ex_cause_i,
  input  logic [XLEN-1:0]       lsu_ex_tval_i,
  // load/store towards memory
  output logic                  lsu_valid_o,
  output logic [PLEN-1:0]       lsu_paddr_o,
  output logic                  lsu_ex_valid_o,
  output logic [XLEN-1:0]       lsu_ex_cause_o,
  output logic [XLEN-1:0]       lsu_ex_tval_o,
  // privilege per path
  input  priv_lvl_e             priv_lvl_i,
  input  priv_lvl_e             ld_st_priv_lvl_i,
  // entry configuration
  input  logic [PMP_CFG_W-1:0]  cfg_i [NR_PMP_ENTRIES],
  input  logic [PMP_ADDR_W-1:0] pmpaddr_i [NR_PMP_ENTRIES]
);

  // pma region test
  logic [PLEN-1:0] exec_offset;
  logic            in_exec_region;

  // pmp verdicts
  logic            fetch_allow;
  logic            data_allow;
  pmp_access_e     data_access;

  // ------------------------------------------------------------------
  // instruction fetch path
  // ------------------------------------------------------------------

  // unsigned offset check also catches addresses below the base
  assign exec_offset    = fetch_paddr_i - EXEC_BASE;
  assign in_exec_region = (exec_offset < EXEC_SIZE);

  // fetch always needs execute permission
  pmp_check u_pmp_fetch (
    .addr_i        (fetch_paddr_i),
    .priv_lvl_i    (priv_lvl_i),
    .access_type_i (ACCESS_EXEC),
    .cfg_i         (cfg_i),
    .pmpaddr_i     (pmpaddr_i),
    .allow_o       (fetch_allow)
  );

  // pass through unless pma or pmp refuses
  // not qualified by fetch_valid_i
  always_comb begin : fetch_path
    fetch_valid_o    = fetch_valid_i;
    fetch_paddr_o    = fetch_paddr_i;
    fetch_ex_valid_o = fetch_ex_valid_i;
    fetch_ex_cause_o = fetch_ex_cause_i;
    fetch_ex_tval_o  = fetch_ex_tval_i;
    if (!in_exec_region || !fetch_allow) begin
      fetch_ex_valid_o = 1'b1;
      fetch_ex_cause_o = CAUSE_INSTR_ACCESS_FAULT;
      fetch_ex_tval_o  = XLEN'(fetch_vaddr_i);
    end
  end

  // ------------------------------------------------------------------
  // load/store path
  // ------------------------------------------------------------------

  // stores check w, loads check r
  assign data_access = lsu_is_store_i ? ACCESS_WRITE : ACCESS_READ;

  pmp_check u_pmp_data (
    .addr_i        (lsu_paddr_i),
    .priv_lvl_i    (ld_st_priv_lvl_i),
    .access_type_i (data_access),
    .cfg_i         (cfg_i),
    .pmpaddr_i     (pmpaddr_i),
    .allow_o       (data_allow)
  );

  // fault only on a valid request
  always_comb begin : data_path
    lsu_valid_o    = lsu_valid_i;
    lsu_paddr_o    = lsu_paddr_i;
    lsu_ex_valid_o = lsu_ex_valid_i;
    lsu_ex_cause_o = lsu_ex_cause_i;
    lsu_ex_tval_o  = lsu_ex_tval_i;
    if (lsu_valid_i && !data_allow) begin
      lsu_ex_valid_o = 1'b1;
      lsu_ex_cause_o = lsu_is_store_i ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
      lsu_ex_tval_o  = XLEN'(lsu_vaddr_i);
    end
  end

endmodule

// File: src/pmp_check.sv
`timescale 1ns/10ps

module pmp_check
  import pmp_pkg::*;
  import mem_cfg_pkg::*;
(
  // physical address under test
  input  logic [PLEN-1:0]       addr_i,
  // effective privilege of the access
  input  priv_lvl_e             priv_lvl_i,
  // selects r, w or x permission
  input  pmp_access_e           access_type_i,
  // entry configuration from the register block
  input  logic [PMP_CFG_W-1:0]  cfg_i [NR_PMP_ENTRIES],
  input  logic [PMP_ADDR_W-1:0] pmpaddr_i [NR_PMP_ENTRIES],
  // access granted
  output logic                  allow_o
);

  // per entry results, index 0 has highest priority
  logic [NR_PMP_ENTRIES-1:0] entry_match;
  logic [NR_PMP_ENTRIES-1:0] entry_perm;
  logic [NR_PMP_ENTRIES-1:0] entry_lock;

  // word address, compared directly against pmpaddr
  logic [PMP_ADDR_W-1:0] word_addr;

  assign word_addr = addr_i[PLEN-1:2];

  // ------------------------------------------------------------------
  // per entry address match and permission lookup
  // ------------------------------------------------------------------

  for (genvar i = 0; i < NR_PMP_ENTRIES; i++) begin : g_entry
    logic [PLEN-1:0]       lo_addr;
    logic [PLEN-1:0]       hi_addr;
    logic [PMP_ADDR_W-1:0] napot_mask;
    pmp_mode_e             mode;
    logic                  hit;
    logic                  perm;

    // tor lower bound, entry 0 starts at address 0
    if (i == 0) begin : g_first
      assign lo_addr = '0;
    end else begin : g_rest
      assign lo_addr = {pmpaddr_i[i-1], 2'b00};
    end

    // tor upper bound, exclusive
    assign hi_addr = {pmpaddr_i[i], 2'b00};

    assign mode = pmp_mode_e'(cfg_i[i][CFG_A_LSB +: CFG_A_W]);

    // napot care mask
    // xor with the incremented value marks trailing ones plus the first zero
    // those bits are don't care, everything above must equal pmpaddr
    assign napot_mask = ~(pmpaddr_i[i] ^ (pmpaddr_i[i] + 1'b1));

    always_comb begin
      unique case (mode)
        TOR:     hit = (addr_i >= lo_addr) && (addr_i < hi_addr);
        NA4:     hit = (word_addr == pmpaddr_i[i]);
        NAPOT:   hit = ((word_addr ^ pmpaddr_i[i]) & napot_mask) == '0;
        default: hit = 1'b0;
      endcase
    end

    // pick the permission bit for this access kind
    always_comb begin
      unique case (access_type_i)
        ACCESS_READ:  perm = cfg_i[i][CFG_R_BIT];
        ACCESS_WRITE: perm = cfg_i[i][CFG_W_BIT];
        ACCESS_EXEC:  perm = cfg_i[i][CFG_X_BIT];
        default:      perm = 1'b0;
      endcase
    end

    assign entry_match[i] = hit;
    assign entry_perm[i]  = perm;
    assign entry_lock[i]  = cfg_i[i][CFG_L_BIT];
  end

  // ------------------------------------------------------------------
  // priority resolution
  // ------------------------------------------------------------------

  // lowest matching index decides
  // no match allows m mode and denies s/u mode
  always_comb begin : resolve
    logic found;

    found   = 1'b0;
    allow_o = (priv_lvl_i == PRIV_M);
    for (int i = 0; i < NR_PMP_ENTRIES; i++) begin
      if (!found && entry_match[i]) begin
        found = 1'b1;
        if (priv_lvl_i == PRIV_M) begin
          // unlocked entries do not restrict m mode
          allow_o = !entry_lock[i] || entry_perm[i];
        end else begin
          allow_o = entry_perm[i];
        end
      end
    end
  end

endmodule

// File: src/pmp_csr_regs.sv
`timescale 1ns/10ps

module pmp_csr_regs
  import pmp_pkg::*;
  import mem_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // single-cycle write strobes
  input  logic                  csr_cfg_we_i,
  input  logic                  csr_addr_we_i,
  // entry select for write and readback
  input  logic [PMP_IDX_W-1:0]  csr_idx_i,
  input  logic [XLEN-1:0]       csr_wdata_i,
  // full entry arrays to the checkers
  output logic [PMP_CFG_W-1:0]  cfg_o [NR_PMP_ENTRIES],
  output logic [PMP_ADDR_W-1:0] addr_o [NR_PMP_ENTRIES],
  // combinational readback of the selected entry
  output logic [PMP_CFG_W-1:0]  csr_cfg_rdata_o,
  output logic [PMP_ADDR_W-1:0] csr_addr_rdata_o
);

  // entry storage
  logic [PMP_CFG_W-1:0]  cfg_q [NR_PMP_ENTRIES];
  logic [PMP_ADDR_W-1:0] addr_q [NR_PMP_ENTRIES];

  // legalized cfg write value
  logic [PMP_CFG_W-1:0] cfg_wdata;

  // write qualifiers
  logic [PMP_IDX_W-1:0] next_idx;
  logic                 entry_locked;
  logic                 next_tor_locked;

  // ------------------------------------------------------------------
  // write rules
  // ------------------------------------------------------------------

  assign next_idx = csr_idx_i + 1'b1;

  always_comb begin : write_rules
    // w without r is reserved, store w as 0
    cfg_wdata = csr_wdata_i[PMP_CFG_W-1:0];
    if (cfg_wdata[CFG_W_BIT] && !cfg_wdata[CFG_R_BIT]) begin
      cfg_wdata[CFG_W_BIT] = 1'b0;
    end

    // locked entry ignores cfg and addr writes
    entry_locked = cfg_q[csr_idx_i][CFG_L_BIT];

    // addr is also the lower bound of a locked tor neighbour
    next_tor_locked = 1'b0;
    if (csr_idx_i != PMP_IDX_W'(NR_PMP_ENTRIES - 1)) begin
      next_tor_locked = cfg_q[next_idx][CFG_L_BIT] &&
                        (pmp_mode_e'(cfg_q[next_idx][CFG_A_LSB +: CFG_A_W]) == TOR);
    end
  end

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------

  // everything clears to OFF with address 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_PMP_ENTRIES; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else begin
      if (csr_cfg_we_i && !entry_locked) begin
        cfg_q[csr_idx_i] <= cfg_wdata;
      end
      // granularity is 4 bytes, upper wdata bits dropped
      if (csr_addr_we_i && !entry_locked && !next_tor_locked) begin
        addr_q[csr_idx_i] <= csr_wdata_i[PMP_ADDR_W-1:0];
      end
    end
  end

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

  // readback follows csr_idx_i in the same cycle
  assign csr_cfg_rdata_o  = cfg_q[csr_idx_i];
  assign csr_addr_rdata_o = addr_q[csr_idx_i];

endmodule

// File: src/pmp_pkg.sv
package pmp_pkg;

  // ------------------------------------------------------------------
  // pmpcfg byte layout
  // ------------------------------------------------------------------

  // one cfg byte per entry
  localparam int PMP_CFG_W = 8;

  // permission bits
  localparam int CFG_R_BIT = 0;
  localparam int CFG_W_BIT = 1;
  localparam int CFG_X_BIT = 2;

  // address-matching mode field, two bits starting here
  localparam int CFG_A_LSB = 3;
  localparam int CFG_A_W   = 2;

  // lock bit, also makes the entry binding for m mode
  localparam int CFG_L_BIT = 7;

  // ------------------------------------------------------------------
  // address-matching modes
  // ------------------------------------------------------------------

  // encoding follows the A field of pmpcfg
  typedef enum logic [1:0] {
    // entry disabled
    OFF   = 2'b00,
    // top of range, lower bound from previous entry
    TOR   = 2'b01,
    // naturally aligned four bytes
    NA4   = 2'b10,
    // naturally aligned power of two, size from trailing ones
    NAPOT = 2'b11
  } pmp_mode_e;

  // ------------------------------------------------------------------
  // access kinds
  // ------------------------------------------------------------------

  // selects which permission bit is checked
  typedef enum logic [1:0] {
    ACCESS_READ  = 2'b00,
    ACCESS_WRITE = 2'b01,
    ACCESS_EXEC  = 2'b10
  } pmp_access_e;

  // ------------------------------------------------------------------
  // privilege levels
  // ------------------------------------------------------------------

  // 2'b10 is reserved, hypervisor mode not supported
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

endpackage

// File: src/pmp_unit_top.sv
`timescale 1ns/10ps

module pmp_unit_top
  import pmp_pkg::*;
  import mem_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // register write and readback
  input  logic                  csr_cfg_we_i,
  input  logic                  csr_addr_we_i,
  input  logic [PMP_IDX_W-1:0]  csr_idx_i,
  input  logic [XLEN-1:0]       csr_wdata_i,
  output logic [PMP_CFG_W-1:0]  csr_cfg_rdata_o,
  output logic [PMP_ADDR_W-1:0] csr_addr_rdata_o,
  // privilege per path
  input  priv_lvl_e             priv_lvl_i,
  input  priv_lvl_e             ld_st_priv_lvl_i,
  // fetch side
  input  logic                  fetch_valid_i,
  input  logic [PLEN-1:0]       fetch_paddr_i,
  input  logic [VLEN-1:0]       fetch_vaddr_i,
  input  logic                  fetch_ex_valid_i,
  input  logic [XLEN-1:0]       fetch_ex_cause_i,
  input  logic [XLEN-1:0]       fetch_ex_tval_i,
  output logic                  fetch_valid_o,
  output logic [PLEN-1:0]       fetch_paddr_o,
  output logic                  fetch_ex_valid_o,
  output logic [XLEN-1:0]       fetch_ex_cause_o,
  output logic [XLEN-1:0]       fetch_ex_tval_o,
  // load/store side
  input  logic                  lsu_valid_i,
  input  logic [PLEN-1:0]       lsu_paddr_i,
  input  logic [VLEN-1:0]       lsu_vaddr_i,
  input  logic                  lsu_is_store_i,
  input  logic                  lsu_ex_valid_i,
  input  logic [XLEN-1:0]       lsu_ex_cause_i,
  input  logic [XLEN-1:0]       lsu_ex_tval_i,
  output logic                  lsu_valid_o,
  output logic [PLEN-1:0]       lsu_paddr_o,
  output logic                  lsu_ex_valid_o,
  output logic [XLEN-1:0]       lsu_ex_cause_o,
  output logic [XLEN-1:0]       lsu_ex_tval_o
);

  // entry arrays, registers to checkers
  logic [PMP_CFG_W-1:0]  pmp_cfg [NR_PMP_ENTRIES];
  logic [PMP_ADDR_W-1:0] pmp_addr [NR_PMP_ENTRIES];

  pmp_csr_regs u_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .csr_cfg_we_i     (csr_cfg_we_i),
    .csr_addr_we_i    (csr_addr_we_i),
    .csr_idx_i        (csr_idx_i),
    .csr_wdata_i      (csr_wdata_i),
    .cfg_o            (pmp_cfg),
    .addr_o           (pmp_addr),
    .csr_cfg_rdata_o  (csr_cfg_rdata_o),
    .csr_addr_rdata_o (csr_addr_rdata_o)
  );

  // both paths checked in parallel, no clocking
  pmp_access_guard u_guard (
    .fetch_valid_i    (fetch_valid_i),
    .fetch_paddr_i    (fetch_paddr_i),
    .fetch_vaddr_i    (fetch_vaddr_i),
    .fetch_ex_valid_i (fetch_ex_valid_i),
    .fetch_ex_cause_i (fetch_ex_cause_i),
    .fetch_ex_tval_i  (fetch_ex_tval_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_paddr_o    (fetch_paddr_o),
    .fetch_ex_valid_o (fetch_ex_valid_o),
    .fetch_ex_cause_o (fetch_ex_cause_o),
    .fetch_ex_tval_o  (fetch_ex_tval_o),
    .lsu_valid_i      (lsu_valid_i),
    .lsu_paddr_i      (lsu_paddr_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .lsu_ex_valid_i   (lsu_ex_valid_i),
    .lsu_ex_cause_i   (lsu_ex_cause_i),
    .lsu_ex_tval_i    (lsu_ex_tval_i),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_ex_valid_o   (lsu_ex_valid_o),
    .lsu_ex_cause_o   (lsu_ex_cause_o),
    .lsu_ex_tval_o    (lsu_ex_tval_o),
    .priv_lvl_i       (priv_lvl_i),
    .ld_st_priv_lvl_i (ld_st_priv_lvl_i),
    .cfg_i            (pmp_cfg),
    .pmpaddr_i        (pmp_addr)
  );

endmodule
